// File: common/mult_op_pkg.sv
package mult_op_pkg;

  // Shift immediate
  localparam int unsigned SHIFT_W = 5;

  // Shift used by the first and third MUL_H steps
  localparam logic [SHIFT_W-1:0] MULH_SHIFT = 5'd16;

  ////////////////////////////////////////
  // Operator encoding
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    MUL_MAC32 = 4'h0,
    MUL_MSU32 = 4'h1,
    MUL_I     = 4'h2,
    MUL_IR    = 4'h3,
    MUL_DOT8  = 4'h4,
    // 4'h5 is free
    MUL_H     = 4'h6,
    MUL_DOT4  = 4'h7
  } mult_op_e;

endpackage

// File: common/mult_width_pkg.sv
package mult_width_pkg;

  localparam int unsigned WORD_W = 32;
  localparam int unsigned HALF_W = 16;

  // Data words and subword lanes
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [HALF_W-1:0] half_t;
  typedef logic [7:0]        byte_lane_t;
  typedef logic [3:0]        nibble_lane_t;

  // Bit 0 marks A as signed, bit 1 marks B as signed
  typedef logic [1:0] sign_sel_t;

endpackage

// File: common/mulh_ctrl_if.sv
`timescale 1ns/1ps

interface mulh_ctrl_if
  import mult_op_pkg::*;
  import mult_width_pkg::*;
();

  logic               active;
  logic [SHIFT_W-1:0] imm;
  logic [1:0]         subword;
  sign_sel_t          signed_sel;
  logic               shift_arith;
  // Carry register control
  logic               save;
  logic               clear;

  modport seq (
    output active, imm, subword, signed_sel, shift_arith, save, clear
  );

  modport dp (
    input active, imm, subword, signed_sel, shift_arith, save, clear
  );

endinterface

// File: hw/int_mac.sv
`timescale 1ns/1ps

module int_mac
  import mult_op_pkg::*;
  import mult_width_pkg::*;
(
  input  mult_op_e operator_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  word_t    op_c_i,
  output word_t    result_o
);

  logic  is_msu;
  word_t op_a_msu;
  word_t op_b_msu;

  assign is_msu = (operator_i == MUL_MSU32);

  // C - A*B = C + (~A)*B + B
  assign op_a_msu = op_a_i ^ {WORD_W{is_msu}};
  assign op_b_msu = op_b_i & {WORD_W{is_msu}};

  // Only the low word is kept
  assign result_o = op_c_i + op_b_msu + op_a_msu * op_b_i;

endmodule

// File: short_mult/short_mult.sv
`timescale 1ns/1ps

module short_mult
  import mult_op_pkg::*;
  import mult_width_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  mult_op_e           operator_i,
  input  logic               short_subword_i,
  input  sign_sel_t          short_signed_i,
  input  word_t              op_a_i,
  input  word_t              op_b_i,
  input  word_t              op_c_i,
  input  logic [SHIFT_W-1:0] imm_i,
  mulh_ctrl_if.dp            ctrl,
  input  logic               carry_clr_i,
  output word_t              result_o
);

  logic [HALF_W:0]    op_a;
  logic [HALF_W:0]    op_b;
  logic [WORD_W:0]    op_c;
  logic [WORD_W+1:0]  mul;
  logic [WORD_W+1:0]  mac;
  logic [WORD_W+1:0]  shifted;
  word_t              round_tmp;
  word_t              round;
  logic [SHIFT_W-1:0] imm;
  logic [1:0]         subword;
  sign_sel_t          signed_sel;
  logic               shift_arith;
  logic               msb1;
  logic               msb0;
  logic               carry_q;

  // MUL_H steps override the instruction fields
  assign imm         = ctrl.active ? ctrl.imm         : imm_i;
  assign subword     = ctrl.active ? ctrl.subword     : {2{short_subword_i}};
  assign signed_sel  = ctrl.active ? ctrl.signed_sel  : short_signed_i;
  assign shift_arith = ctrl.active ? ctrl.shift_arith : short_signed_i[0];

  // Half of the weight of the shift, MUL_IR only
  assign round_tmp = word_t'(1) << imm_i;
  assign round     = (operator_i == MUL_IR) ? {1'b0, round_tmp[WORD_W-1:1]} : '0;

  // Halfword select with optional sign extension
  assign op_a[HALF_W-1:0] = subword[0] ? op_a_i[WORD_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign op_b[HALF_W-1:0] = subword[1] ? op_b_i[WORD_W-1:HALF_W] : op_b_i[HALF_W-1:0];
  assign op_a[HALF_W]     = signed_sel[0] & op_a[HALF_W-1];
  assign op_b[HALF_W]     = signed_sel[1] & op_b[HALF_W-1];

  // The saved carry extends the accumulator during MUL_H
  assign op_c = ctrl.active ? {carry_q, op_c_i} : {op_c_i[WORD_W-1], op_c_i};

  assign mul = $signed(op_a) * $signed(op_b);
  assign mac = $signed(op_c) + $signed(mul) + $signed(round);

  assign msb1 = ctrl.active ? mac[WORD_W+1] : mac[WORD_W-1];
  assign msb0 = ctrl.active ? mac[WORD_W]   : mac[WORD_W-1];

  assign shifted  = $signed({shift_arith & msb1, shift_arith & msb0, mac[WORD_W-1:0]}) >>> imm;
  assign result_o = shifted[WORD_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q <= 1'b0;
    end else if (ctrl.save) begin
      carry_q <= ~ctrl.clear & mac[WORD_W];
    end else if (carry_clr_i) begin
      carry_q <= 1'b0;
    end
  end

endmodule

// File: short_mult/mulh_sequencer.sv
`timescale 1ns/1ps

module mulh_sequencer
  import mult_op_pkg::*;
  import mult_width_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_op_e  operator_i,
  input  sign_sel_t short_signed_i,
  input  logic      ex_ready_i,
  mulh_ctrl_if.seq  ctrl,
  output logic      carry_clr_o,
  output logic      multicycle_o,
  output logic      ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

  mulh_state_e state_q;
  mulh_state_e state_d;

  ////////////////////////////////////////
  // Step control
  ////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    ctrl.active      = 1'b1;
    ctrl.imm         = '0;
    ctrl.subword     = 2'b00;
    ctrl.signed_sel  = 2'b00;
    ctrl.shift_arith = 1'b0;
    ctrl.save        = 1'b0;
    ctrl.clear       = 1'b0;
    multicycle_o     = 1'b0;
    ready_o          = 1'b0;

    case (state_q)
      IDLE: begin
        ctrl.active = 1'b0;
        ready_o     = 1'b1;
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // AL*BL, unsigned and never overflows
        multicycle_o = 1'b1;
        ctrl.imm     = MULH_SHIFT;
        state_d      = STEP1;
      end
      STEP1: begin
        // AL*BH keeps the sign of B, carry becomes the extension
        multicycle_o     = 1'b1;
        ctrl.signed_sel  = {short_signed_i[1], 1'b0};
        ctrl.subword     = 2'b10;
        ctrl.shift_arith = 1'b1;
        ctrl.save        = 1'b1;
        state_d          = STEP2;
      end
      STEP2: begin
        // AH*BL keeps the sign of A, the upper bits are shifted out
        multicycle_o     = 1'b1;
        ctrl.signed_sel  = {1'b0, short_signed_i[0]};
        ctrl.subword     = 2'b01;
        ctrl.imm         = MULH_SHIFT;
        ctrl.shift_arith = 1'b1;
        ctrl.save        = 1'b1;
        ctrl.clear       = 1'b1;
        state_d          = FINISH;
      end
      FINISH: begin
        // AH*BH with both signs, held until the stage accepts it
        ctrl.signed_sel = short_signed_i;
        ctrl.subword    = 2'b11;
        ready_o         = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Drop the carry once the result moves on
  assign carry_clr_o = ~ctrl.save & ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: dot_mult/dot_lane_sum.sv
`timescale 1ns/1ps

module dot_lane_sum
  import mult_width_pkg::*;
#(
  parameter type lane_t = byte_lane_t
) (
  input  sign_sel_t signed_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  word_t     op_c_i,
  output word_t     result_o
);

  localparam int unsigned LANE_W    = $bits(lane_t);
  localparam int unsigned NUM_LANES = WORD_W / LANE_W;

  word_t prod [NUM_LANES];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_t           lane_a;
    lane_t           lane_b;
    logic [LANE_W:0] a_ext;
    logic [LANE_W:0] b_ext;

    assign lane_a = op_a_i[i*LANE_W +: LANE_W];
    assign lane_b = op_b_i[i*LANE_W +: LANE_W];
    assign a_ext  = {signed_i[0] & lane_a[LANE_W-1], lane_a};
    assign b_ext  = {signed_i[1] & lane_b[LANE_W-1], lane_b};

    // Extended to a full word before the multiply
    assign prod[i] = $signed(a_ext) * $signed(b_ext);
  end

  // Accumulator plus all lane products, wraps at 32 bits
  always_comb begin
    result_o = op_c_i;
    for (int i = 0; i < NUM_LANES; i++) begin
      result_o = result_o + prod[i];
    end
  end

endmodule

// File: hw/nn_mult_top.sv
`timescale 1ns/1ps

module nn_mult_top
  import mult_op_pkg::*;
  import mult_width_pkg::*;
#(
  parameter bit DOT_EN = 1'b1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  mult_op_e           operator_i,
  input  logic               short_subword_i,
  input  sign_sel_t          short_signed_i,
  input  sign_sel_t          dot_signed_i,
  input  word_t              op_a_i,
  input  word_t              op_b_i,
  input  word_t              op_c_i,
  input  logic [SHIFT_W-1:0] imm_i,
  input  logic               ex_ready_i,
  output word_t              result_o,
  output logic               multicycle_o,
  output logic               ready_o
);

  word_t short_op_c;
  word_t short_result;
  word_t int_result;
  word_t dot8_result;
  word_t dot4_result;
  word_t mulh_acc_q;
  logic  carry_clr;
  logic  mulh_multicycle;

  mulh_ctrl_if mulh_ctrl ();

  ////////////////////////////////////////
  // MUL_H sequencing and short path
  ////////////////////////////////////////

  mulh_sequencer mulh_sequencer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator_i),
    .short_signed_i (short_signed_i),
    .ex_ready_i     (ex_ready_i),
    .ctrl           (mulh_ctrl),
    .carry_clr_o    (carry_clr),
    .multicycle_o   (mulh_multicycle),
    .ready_o        (ready_o)
  );

  // Each step accumulates on the result of the step before
  always_ff @(posedge clk) begin
    if (!mulh_ctrl.active) begin
      mulh_acc_q <= '0;
    end else if (mulh_multicycle) begin
      mulh_acc_q <= short_result;
    end
  end

  assign short_op_c = (operator_i == MUL_H) ? mulh_acc_q : op_c_i;

  short_mult short_mult_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .operator_i      (operator_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (short_op_c),
    .imm_i           (imm_i),
    .ctrl            (mulh_ctrl),
    .carry_clr_i     (carry_clr),
    .result_o        (short_result)
  );

  int_mac int_mac_inst (
    .operator_i (operator_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .op_c_i     (op_c_i),
    .result_o   (int_result)
  );

  ////////////////////////////////////////
  // Dot products
  ////////////////////////////////////////

  if (DOT_EN) begin : g_dot
    dot_lane_sum #(.lane_t(byte_lane_t)) dot8_inst (
      .signed_i (dot_signed_i),
      .op_a_i   (op_a_i),
      .op_b_i   (op_b_i),
      .op_c_i   (op_c_i),
      .result_o (dot8_result)
    );

    dot_lane_sum #(.lane_t(nibble_lane_t)) dot4_inst (
      .signed_i (dot_signed_i),
      .op_a_i   (op_a_i),
      .op_b_i   (op_b_i),
      .op_c_i   (op_c_i),
      .result_o (dot4_result)
    );
  end else begin : g_no_dot
    assign dot8_result = '0;
    assign dot4_result = '0;
  end

  // Result select
  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT4:             result_o = dot4_result;
      default:              result_o = '0;
    endcase
  end

  assign multicycle_o = mulh_multicycle;

endmodule

// File: sim/nn_mult_tb.sv
`timescale 1ns/1ps

module nn_mult_tb
  import mult_op_pkg::*;
  import mult_width_pkg::*;
();

  localparam int MAX_ENTRIES = 80;
  localparam int NUM_RANDOM  = 48;
  localparam int MAX_WAIT    = 20;

  typedef struct packed {
    logic [3:0]  op;
    logic [1:0]  short_signed;
    logic [1:0]  dot_signed;
    logic        subword;
    logic [4:0]  imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [3:0]  hold;
  } entry_t;

  logic               clk;
  logic               rst_n;
  logic               enable_i;
  mult_op_e           operator_i;
  logic               short_subword_i;
  sign_sel_t          short_signed_i;
  sign_sel_t          dot_signed_i;
  word_t              op_a_i;
  word_t              op_b_i;
  word_t              op_c_i;
  logic [SHIFT_W-1:0] imm_i;
  logic               ex_ready_i;
  word_t              result_o;
  logic               multicycle_o;
  logic               ready_o;

  entry_t      stim [MAX_ENTRIES];
  int          num_entries;
  int          cur_entry;
  int          check_count;
  int          error_count;
  int          timeout_count;
  int unsigned seed_value;

  nn_mult_top #(
    .DOT_EN (1'b1)
  ) nn_mult_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .dot_signed_i    (dot_signed_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .ex_ready_i      (ex_ready_i),
    .result_o        (result_o),
    .multicycle_o    (multicycle_o),
    .ready_o         (ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s (entry %0d) expected 0x%08h, got 0x%08h",
               $time, name, cur_entry, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Keeps the low width bits of value and sign-extends them when sgn is set
  function automatic longint extend(input logic [31:0] value, input int width, input logic sgn);
    longint r;
    r = value & ((64'd1 << width) - 1);
    if (sgn && value[width-1]) begin
      r = r - (64'sd1 << width);
    end
    return r;
  endfunction

  function automatic logic [31:0] model_result(input entry_t e);
    longint      a;
    longint      b;
    longint      prod;
    logic [31:0] sum;
    logic [31:0] rnd;
    int          lw;
    model_result = '0;
    case (e.op)
      MUL_MAC32: model_result = e.c + e.a * e.b;
      MUL_MSU32: model_result = e.c - e.a * e.b;
      MUL_I, MUL_IR: begin
        a    = extend(e.subword ? e.a >> 16 : e.a, 16, e.short_signed[0]);
        b    = extend(e.subword ? e.b >> 16 : e.b, 16, e.short_signed[1]);
        prod = a * b;
        rnd  = (e.op == MUL_IR && e.imm != 0) ? 32'd1 << (e.imm - 1) : 32'd0;
        sum  = e.c + prod[31:0] + rnd;
        if (e.short_signed[0]) begin
          model_result = $signed(sum) >>> e.imm;
        end else begin
          model_result = sum >> e.imm;
        end
      end
      MUL_H: begin
        a    = extend(e.a, 32, e.short_signed[0]);
        b    = extend(e.b, 32, e.short_signed[1]);
        prod = a * b;
        model_result = prod[63:32];
      end
      MUL_DOT8, MUL_DOT4: begin
        lw  = (e.op == MUL_DOT8) ? 8 : 4;
        sum = e.c;
        for (int i = 0; i < 32 / lw; i++) begin
          a    = extend(e.a >> (i * lw), lw, e.dot_signed[0]);
          b    = extend(e.b >> (i * lw), lw, e.dot_signed[1]);
          prod = a * b;
          sum  = sum + prod[31:0];
        end
        model_result = sum;
      end
      default: model_result = '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic add_entry(input mult_op_e op, input logic [1:0] ssg, input logic [1:0] dsg,
                           input logic sub, input logic [4:0] imm, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c, input logic [3:0] hold);
    entry_t e;
    e.op           = op;
    e.short_signed = ssg;
    e.dot_signed   = dsg;
    e.subword      = sub;
    e.imm          = imm;
    e.a            = a;
    e.b            = b;
    e.c            = c;
    e.hold         = hold;
    stim[num_entries] = e;
    num_entries++;
  endtask

  task automatic build_table();
    mult_op_e   op;
    logic [1:0] ssg;
    logic [3:0] hold;
    // Corner values first
    add_entry(MUL_MAC32, 2'b00, 2'b00, 1'b0, 5'd0, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 4'd0);
    add_entry(MUL_MAC32, 2'b00, 2'b00, 1'b0, 5'd0, 32'h7fff_ffff, 32'h2, 32'h1, 4'd0);
    add_entry(MUL_MSU32, 2'b00, 2'b00, 1'b0, 5'd0, 32'h1234_5678, 32'h9abc_def0, 32'h0, 4'd0);
    add_entry(MUL_MSU32, 2'b00, 2'b00, 1'b0, 5'd0, 32'h0, 32'h0000_ffff, 32'h5, 4'd0);
    add_entry(MUL_I, 2'b11, 2'b00, 1'b0, 5'd0, 32'h0000_8000, 32'h0000_8000, 32'h0, 4'd0);
    add_entry(MUL_I, 2'b00, 2'b00, 1'b1, 5'd4, 32'hffff_0000, 32'hffff_0000, 32'h0, 4'd0);
    add_entry(MUL_IR, 2'b11, 2'b00, 1'b0, 5'd31, 32'h7fff, 32'h7fff, 32'h8000_0000, 4'd0);
    add_entry(MUL_IR, 2'b01, 2'b00, 1'b1, 5'd1, 32'h8000_0000, 32'hffff_0000, 32'hffff_ffff,
              4'd0);
    add_entry(MUL_H, 2'b11, 2'b00, 1'b0, 5'd0, 32'h8000_0000, 32'h8000_0000, 32'h0, 4'd0);
    add_entry(MUL_H, 2'b11, 2'b00, 1'b0, 5'd0, 32'hffff_ffff, 32'h1, 32'h0, 4'd0);
    add_entry(MUL_H, 2'b01, 2'b00, 1'b0, 5'd0, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 4'd0);
    add_entry(MUL_H, 2'b00, 2'b00, 1'b0, 5'd0, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 4'd0);
    add_entry(MUL_H, 2'b11, 2'b00, 1'b0, 5'd0, 32'h1234_5678, 32'h8765_4321, 32'h0, 4'd3);
    add_entry(MUL_H, 2'b00, 2'b00, 1'b0, 5'd0, 32'hdead_beef, 32'h0bad_f00d, 32'h0, 4'd1);
    for (int s = 0; s < 4; s++) begin
      add_entry(MUL_DOT8, 2'b00, s[1:0], 1'b0, 5'd0, 32'h80ff_7f01, 32'hff80_017f,
                32'h0000_1000, 4'd0);
      add_entry(MUL_DOT4, 2'b00, s[1:0], 1'b0, 5'd0, 32'hf87f_1e8c, 32'h8f71_e3c8,
                32'hffff_fff0, 4'd0);
    end
    // Random entries
    for (int i = 0; i < NUM_RANDOM; i++) begin
      case ($urandom % 7)
        0:       op = MUL_MAC32;
        1:       op = MUL_MSU32;
        2:       op = MUL_I;
        3:       op = MUL_IR;
        4:       op = MUL_H;
        5:       op = MUL_DOT8;
        default: op = MUL_DOT4;
      endcase
      ssg  = $urandom % 4;
      hold = 4'd0;
      if (op == MUL_H) begin
        // Signed, signed by unsigned and unsigned forms only
        case ($urandom % 3)
          0:       ssg = 2'b11;
          1:       ssg = 2'b01;
          default: ssg = 2'b00;
        endcase
        if ($urandom % 4 == 0) begin
          hold = 1 + $urandom % 3;
        end
      end
      add_entry(op, ssg, $urandom % 4, $urandom % 2, $urandom % 32, $urandom, $urandom,
                $urandom, hold);
    end
  endtask

  ////////////////////////////////////////
  // Apply and check one entry
  ////////////////////////////////////////

  task automatic apply_entry(input int idx);
    entry_t      e;
    logic [31:0] expected;
    int          cycles;
    int          busy_cycles;
    e         = stim[idx];
    expected  = model_result(e);
    cur_entry = idx;
    @(posedge clk);
    #1;
    enable_i        = 1'b1;
    operator_i      = mult_op_e'(e.op);
    short_signed_i  = e.short_signed;
    dot_signed_i    = e.dot_signed;
    short_subword_i = e.subword;
    imm_i           = e.imm;
    op_a_i          = e.a;
    op_b_i          = e.b;
    op_c_i          = e.c;
    ex_ready_i      = (e.hold == 0);
    @(negedge clk);
    if (e.op != MUL_H) begin
      check_value("result_o", expected, result_o);
      check_value("ready_o", 32'd1, ready_o);
      check_value("multicycle_o", 32'd0, multicycle_o);
    end else begin
      check_value("ready_o", 32'd0, ready_o);
      cycles      = 0;
      busy_cycles = 0;
      while (ready_o !== 1'b1 && cycles < MAX_WAIT) begin
        @(negedge clk);
        cycles++;
        if (multicycle_o === 1'b1) begin
          busy_cycles++;
        end
      end
      if (ready_o !== 1'b1) begin
        $display("Timeout: ready_o stayed low for %0d cycles on MUL_H entry %0d",
                 MAX_WAIT, idx);
        timeout_count++;
      end else begin
        check_value("ready_o cycle count", 32'd4, cycles);
        check_value("multicycle_o cycle count", 32'd3, busy_cycles);
        check_value("result_o", expected, result_o);
        // FINISH held under back-pressure
        repeat (e.hold) begin
          @(negedge clk);
          check_value("ready_o", 32'd1, ready_o);
          check_value("multicycle_o", 32'd0, multicycle_o);
          check_value("result_o", expected, result_o);
        end
        if (e.hold != 0) begin
          @(posedge clk);
          #1;
          ex_ready_i = 1'b1;
          @(negedge clk);
          check_value("result_o", expected, result_o);
        end
      end
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    enable_i        = 1'b0;
    operator_i      = MUL_MAC32;
    short_subword_i = 1'b0;
    short_signed_i  = 2'b00;
    dot_signed_i    = 2'b00;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    imm_i           = '0;
    ex_ready_i      = 1'b1;
    num_entries     = 0;
    cur_entry       = -1;
    check_count     = 0;
    error_count     = 0;
    timeout_count   = 0;
    seed_value      = 32'h4c16_8a2b;
    void'($urandom(seed_value));
    build_table();

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    check_value("ready_o", 32'd1, ready_o);
    check_value("multicycle_o", 32'd0, multicycle_o);

    for (int i = 0; i < num_entries && timeout_count == 0; i++) begin
      apply_entry(i);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: nn_mult.f
common/mult_op_pkg.sv
common/mult_width_pkg.sv
common/mulh_ctrl_if.sv
hw/int_mac.sv
short_mult/short_mult.sv
short_mult/mulh_sequencer.sv
dot_mult/dot_lane_sum.sv
hw/nn_mult_top.sv
sim/nn_mult_tb.sv

// File: Bender.yml
package:
  name: nn_mult

sources:
  # Shared packages and interface
  - common/mult_op_pkg.sv
  - common/mult_width_pkg.sv
  - common/mulh_ctrl_if.sv
  # Datapath units
  - hw/int_mac.sv
  - short_mult/short_mult.sv
  - short_mult/mulh_sequencer.sv
  - dot_mult/dot_lane_sum.sv
  # Top level
  - hw/nn_mult_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/nn_mult_tb.sv
